// File: source/eth_tx_pkg.sv
`default_nettype none

package eth_tx_pkg;

   // frame format
   localparam int PREAMBLE_LEN = 7;
   localparam int HDR_BYTES = PREAMBLE_LEN + 1;
   localparam int FCS_NIBBLES = 8;

   // reflected ethernet polynomial
   localparam logic [31:0] CRC32_POLY = 32'hEDB8_8320;
   localparam logic [31:0] CRC32_INIT = 32'hFFFF_FFFF;

   // register map
   localparam logic [1:0] REG_LEN = 2'd0;
   localparam logic [1:0] REG_CTRL = 2'd1;
   localparam logic [1:0] REG_STATUS = 2'd2;
   localparam logic [1:0] REG_COUNT = 2'd3;

   // control and status bits
   localparam int CTRL_SEND_BIT = 0;
   localparam int CTRL_CLR_LOST_BIT = 1;
   localparam int STAT_READY_BIT = 0;
   localparam int STAT_LOST_BIT = 1;

endpackage

`default_nettype wire

// File: source/eth_tx_frame_buf.sv
`default_nettype none

module eth_tx_frame_buf #(
   parameter int ADDR_W = 11
) (
   input wire               TX_CLK,

   // host write side
   input wire               buf_wr_en,
   input wire  [ADDR_W-1:0] buf_wr_addr,
   input wire  [7:0]        buf_wr_data,

   // transmitter read side
   input wire  [ADDR_W-1:0] rd_addr,
   output logic [7:0]       rd_data
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic [7:0] mem [DEPTH];

   always_ff @(posedge TX_CLK) begin
      if (buf_wr_en) begin
         mem[buf_wr_addr] <= buf_wr_data;
      end
   end

   // one cycle read latency
   always_ff @(posedge TX_CLK) begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// File: source/eth_tx_ctrl_regs.sv
`default_nettype none

module eth_tx_ctrl_regs #(
   parameter int ADDR_W = 11
) (
   input wire             TX_CLK,
   input wire             tx_rst,

   // host register port
   input wire             reg_wr_en,
   input wire  [1:0]      reg_addr,
   input wire  [15:0]     reg_wdata,
   output logic [15:0]    reg_rdata,

   // to and from the sequencer
   input wire             tx_ready,
   output logic           tx_send,
   output logic [ADDR_W:0] tx_len
);

   logic        lost;
   logic [15:0] frame_cnt;
   logic        ready_q;

   logic ctrl_wr;
   logic send_req;
   logic clr_lost;

   assign ctrl_wr  = reg_wr_en && (reg_addr == eth_tx_pkg::REG_CTRL);
   assign send_req = ctrl_wr && reg_wdata[eth_tx_pkg::CTRL_SEND_BIT];
   assign clr_lost = ctrl_wr && reg_wdata[eth_tx_pkg::CTRL_CLR_LOST_BIT];

   always_ff @(posedge TX_CLK or posedge tx_rst) begin
      if (tx_rst) begin
         tx_len    <= '0;
         tx_send   <= 1'b0;
         lost      <= 1'b0;
         frame_cnt <= '0;
         ready_q   <= 1'b1;
      end else begin
         // one cycle strobe per send write
         tx_send <= send_req;

         if (reg_wr_en && (reg_addr == eth_tx_pkg::REG_LEN)) begin
            tx_len <= reg_wdata[ADDR_W:0];
         end

         // set wins over clear in the same write
         if (send_req && (!tx_ready || tx_send)) begin
            lost <= 1'b1;
         end else if (clr_lost) begin
            lost <= 1'b0;
         end

         // count completed frames
         ready_q <= tx_ready;
         if (tx_ready && !ready_q) begin
            frame_cnt <= frame_cnt + 16'd1;
         end
      end
   end

   always_comb begin
      reg_rdata = '0;
      case (reg_addr)
         eth_tx_pkg::REG_LEN: reg_rdata = 16'(tx_len);
         eth_tx_pkg::REG_STATUS: begin
            reg_rdata[eth_tx_pkg::STAT_READY_BIT] = tx_ready;
            reg_rdata[eth_tx_pkg::STAT_LOST_BIT]  = lost;
         end
         eth_tx_pkg::REG_COUNT: reg_rdata = frame_cnt;
         default: reg_rdata = '0;
      endcase
   end

   a_send_pulse: assert property (@(posedge TX_CLK) disable iff (tx_rst)
      tx_send |=> !tx_send);

endmodule

`default_nettype wire

// File: source/eth_crc32.sv
`default_nettype none

module eth_crc32 (
   input wire          TX_CLK,
   input wire          tx_rst,

   input wire          crc_start,
   input wire          crc_en,
   input wire  [7:0]   data_in,
   output logic [31:0] crc_value
);

   // one byte through the reflected lfsr, lsb first
   function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] d);
      logic [31:0] c;
      int          i;
      c = crc;
      for (i = 0; i < 8; i++) begin
         c = (c >> 1) ^ (eth_tx_pkg::CRC32_POLY & {32{c[0] ^ d[i]}});
      end
      return c;
   endfunction

   always_ff @(posedge TX_CLK or posedge tx_rst) begin
      if (tx_rst) begin
         crc_value <= eth_tx_pkg::CRC32_INIT;
      end else if (crc_start) begin
         crc_value <= eth_tx_pkg::CRC32_INIT;
      end else if (crc_en) begin
         crc_value <= crc_byte(crc_value, data_in);
      end
   end

   // sequencer only clears while idle, never mid payload
   a_start_en: assert property (@(posedge TX_CLK) disable iff (tx_rst)
      !(crc_start && crc_en));

endmodule

`default_nettype wire

// File: source/eth_mii_tx.sv
`default_nettype none

module eth_mii_tx #(
   parameter int ADDR_W = 11
) (
   input wire               TX_CLK,
   input wire               tx_rst,

   // send request from the register block
   input wire               tx_send,
   input wire  [ADDR_W:0]   tx_len,
   output logic             tx_ready,

   // frame buffer read
   output logic [ADDR_W-1:0] rd_addr,
   input wire  [7:0]        rd_data,

   // crc accumulator
   output logic             crc_start,
   output logic             crc_en,
   input wire  [31:0]       crc_value,

   // mii
   output logic             mii_tx_en,
   output logic [3:0]       mii_txd
);

   localparam int FCS_W = $clog2(eth_tx_pkg::FCS_NIBBLES);

   // phase program
   localparam logic [2:0] PH_IDLE   = 3'd0;
   localparam logic [2:0] PH_HDR_LO = 3'd1;
   localparam logic [2:0] PH_HDR_HI = 3'd2;
   localparam logic [2:0] PH_DAT_LO = 3'd3;
   localparam logic [2:0] PH_DAT_HI = 3'd4;
   localparam logic [2:0] PH_FCS    = 3'd5;
   localparam logic [2:0] PH_DONE   = 3'd6;

   logic [2:0]       phase;
   logic [ADDR_W:0]  byte_cnt;
   logic [ADDR_W:0]  len_q;
   logic [FCS_W-1:0] fcs_cnt;
   logic [31:0]      fcs_word;

   assign rd_addr   = byte_cnt[ADDR_W-1:0];
   assign crc_start = (phase == PH_IDLE);
   // transmitted fcs is the complement, lsb first
   assign fcs_word  = ~crc_value;

   always_ff @(posedge TX_CLK or posedge tx_rst) begin
      if (tx_rst) begin
         phase     <= PH_IDLE;
         byte_cnt  <= '0;
         len_q     <= '0;
         fcs_cnt   <= '0;
         crc_en    <= 1'b0;
         tx_ready  <= 1'b1;
         mii_tx_en <= 1'b0;
         mii_txd   <= 4'd0;
      end else begin
         crc_en <= 1'b0;

         case (phase)
            PH_IDLE: begin
               if (tx_send) begin
                  tx_ready <= 1'b0;
                  len_q    <= tx_len;
                  phase    <= PH_HDR_LO;
               end
            end

            PH_HDR_LO: begin
               mii_tx_en <= 1'b1;
               mii_txd   <= rd_data[3:0];
               byte_cnt  <= byte_cnt + 1'b1;
               phase     <= PH_HDR_HI;
            end

            // rd_data still holds the old byte on this edge
            PH_HDR_HI: begin
               mii_txd <= rd_data[7:4];
               if (byte_cnt == (ADDR_W+1)'(eth_tx_pkg::HDR_BYTES)) begin
                  crc_en <= 1'b1;
                  phase  <= PH_DAT_LO;
               end else begin
                  phase <= PH_HDR_LO;
               end
            end

            PH_DAT_LO: begin
               mii_txd  <= rd_data[3:0];
               byte_cnt <= byte_cnt + 1'b1;
               phase    <= PH_DAT_HI;
            end

            PH_DAT_HI: begin
               mii_txd <= rd_data[7:4];
               if (byte_cnt < len_q) begin
                  crc_en <= 1'b1;
                  phase  <= PH_DAT_LO;
               end else begin
                  fcs_cnt <= '0;
                  phase   <= PH_FCS;
               end
            end

            PH_FCS: begin
               mii_txd <= fcs_word[4*fcs_cnt +: 4];
               fcs_cnt <= fcs_cnt + 1'b1;
               if (fcs_cnt == FCS_W'(eth_tx_pkg::FCS_NIBBLES - 1)) begin
                  phase <= PH_DONE;
               end
            end

            PH_DONE: begin
               mii_tx_en <= 1'b0;
               mii_txd   <= 4'd0;
               tx_ready  <= 1'b1;
               byte_cnt  <= '0;
               phase     <= PH_IDLE;
            end

            default: begin
               phase     <= PH_IDLE;
               byte_cnt  <= '0;
               tx_ready  <= 1'b1;
               mii_tx_en <= 1'b0;
               mii_txd   <= 4'd0;
            end
         endcase
      end
   end

   // start latency from the send strobe
   a_en_after_send: assert property (@(posedge TX_CLK) disable iff (tx_rst)
      $rose(mii_tx_en) |-> $past(tx_send, 2));

endmodule

`default_nettype wire

// File: source/eth_tx_top.sv
`default_nettype none

module eth_tx_top #(
   parameter int ADDR_W = 11
) (
   input wire               TX_CLK,
   input wire               tx_rst,

   // register port
   input wire               reg_wr_en,
   input wire  [1:0]        reg_addr,
   input wire  [15:0]       reg_wdata,
   output wire [15:0]       reg_rdata,

   // frame buffer write port
   input wire               buf_wr_en,
   input wire  [ADDR_W-1:0] buf_wr_addr,
   input wire  [7:0]        buf_wr_data,

   // mii transmit
   output wire              mii_tx_en,
   output wire [3:0]        mii_txd
);

   wire              tx_send;
   wire [ADDR_W:0]   tx_len;
   wire              tx_ready;
   wire [ADDR_W-1:0] rd_addr;
   wire [7:0]        rd_data;
   wire              crc_start;
   wire              crc_en;
   wire [31:0]       crc_value;

   eth_tx_frame_buf #(
      .ADDR_W(ADDR_W)
   ) u_frame_buf (
      .TX_CLK     (TX_CLK),
      .buf_wr_en  (buf_wr_en),
      .buf_wr_addr(buf_wr_addr),
      .buf_wr_data(buf_wr_data),
      .rd_addr    (rd_addr),
      .rd_data    (rd_data)
   );

   eth_tx_ctrl_regs #(
      .ADDR_W(ADDR_W)
   ) u_ctrl_regs (
      .TX_CLK   (TX_CLK),
      .tx_rst   (tx_rst),
      .reg_wr_en(reg_wr_en),
      .reg_addr (reg_addr),
      .reg_wdata(reg_wdata),
      .reg_rdata(reg_rdata),
      .tx_ready (tx_ready),
      .tx_send  (tx_send),
      .tx_len   (tx_len)
   );

   eth_mii_tx #(
      .ADDR_W(ADDR_W)
   ) u_mii_tx (
      .TX_CLK   (TX_CLK),
      .tx_rst   (tx_rst),
      .tx_send  (tx_send),
      .tx_len   (tx_len),
      .tx_ready (tx_ready),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data),
      .crc_start(crc_start),
      .crc_en   (crc_en),
      .crc_value(crc_value),
      .mii_tx_en(mii_tx_en),
      .mii_txd  (mii_txd)
   );

   // crc sees buffer data directly
   eth_crc32 u_crc (
      .TX_CLK   (TX_CLK),
      .tx_rst   (tx_rst),
      .crc_start(crc_start),
      .crc_en   (crc_en),
      .data_in  (rd_data),
      .crc_value(crc_value)
   );

endmodule

`default_nettype wire

// File: sim/eth_tx_tb.sv
`default_nettype none

module eth_tx_tb;

   localparam int ADDR_W = 11;
   localparam int MAX_WAIT = 5000;
   localparam int N_RANDOM = 4;

   logic              TX_CLK;
   logic              tx_rst;
   logic              reg_wr_en;
   logic [1:0]        reg_addr;
   logic [15:0]       reg_wdata;
   wire  [15:0]       reg_rdata;
   logic              buf_wr_en;
   logic [ADDR_W-1:0] buf_wr_addr;
   logic [7:0]        buf_wr_data;
   wire               mii_tx_en;
   wire  [3:0]        mii_txd;

   // expected buffer image
   logic [7:0]  frame [2**ADDR_W];
   logic [3:0]  nib_q[$];
   logic [3:0]  done_q[$];
   logic [31:0] lcg_state;
   logic        accept_wr;
   int          frames_seen;
   int          frames_expected;
   int          errors;
   int          timeouts;

   eth_tx_top #(
      .ADDR_W(ADDR_W)
   ) u_eth_tx_top (
      .TX_CLK     (TX_CLK),
      .tx_rst     (tx_rst),
      .reg_wr_en  (reg_wr_en),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_rdata  (reg_rdata),
      .buf_wr_en  (buf_wr_en),
      .buf_wr_addr(buf_wr_addr),
      .buf_wr_data(buf_wr_data),
      .mii_tx_en  (mii_tx_en),
      .mii_txd    (mii_txd)
   );

   initial begin
      TX_CLK = 1'b0;
      forever #4 TX_CLK = ~TX_CLK;
   end

   // frame starts three edges after an accepted send write
   a_start_latency: assert property (@(posedge TX_CLK) disable iff (tx_rst)
      $rose(mii_tx_en) == $past(accept_wr, 3))
      else begin
         errors++;
         $display("Mismatch at %0t: mii_tx_en start does not match send write", $time);
      end

   a_idle_data: assert property (@(posedge TX_CLK) disable iff (tx_rst)
      !mii_tx_en |-> (mii_txd == 4'd0))
      else begin
         errors++;
         $display("Mismatch at %0t: mii_txd not zero while idle", $time);
      end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // inverted reflected crc-32 over frame[first .. last-1]
   function automatic logic [31:0] ref_fcs(input int first, input int last);
      logic [31:0] c;
      c = 32'hFFFF_FFFF;
      for (int i = first; i < last; i++) begin
         c = c ^ {24'd0, frame[i]};
         for (int b = 0; b < 8; b++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
         end
      end
      return ~c;
   endfunction

   // mii monitor collects one frame per tx_en burst
   always @(negedge TX_CLK) begin
      if (mii_tx_en) begin
         nib_q.push_back(mii_txd);
      end else if (nib_q.size() != 0) begin
         done_q = nib_q;
         nib_q.delete();
         frames_seen++;
      end
   end

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      assert (got == exp) else begin
         errors++;
         $display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic reg_write(input logic [1:0] addr, input logic [15:0] data);
      reg_wr_en = 1'b1;
      reg_addr  = addr;
      reg_wdata = data;
      @(posedge TX_CLK);
      #1;
      reg_wr_en = 1'b0;
      accept_wr = 1'b0;
   endtask

   task automatic reg_read(input logic [1:0] addr, output logic [15:0] data);
      reg_addr = addr;
      @(posedge TX_CLK);
      #1;
      data = reg_rdata;
   endtask

   task automatic send_frame(input logic accepted);
      accept_wr = accepted;
      if (accepted) begin
         frames_expected++;
      end
      reg_write(eth_tx_pkg::REG_CTRL, 16'(1 << eth_tx_pkg::CTRL_SEND_BIT));
   endtask

   // header, then "123456789..." or lcg bytes
   task automatic load_frame(input int len, input logic fixed);
      for (int i = 0; i < len; i++) begin
         if (i < eth_tx_pkg::PREAMBLE_LEN) begin
            frame[i] = 8'h55;
         end else if (i == eth_tx_pkg::PREAMBLE_LEN) begin
            frame[i] = 8'hD5;
         end else if (fixed) begin
            frame[i] = 8'(8'h31 + i - eth_tx_pkg::HDR_BYTES);
         end else begin
            lcg_state = lcg_next(lcg_state);
            frame[i] = lcg_state[23:16];
         end
         buf_wr_en   = 1'b1;
         buf_wr_addr = ADDR_W'(i);
         buf_wr_data = frame[i];
         @(posedge TX_CLK);
         #1;
      end
      buf_wr_en = 1'b0;
      reg_write(eth_tx_pkg::REG_LEN, 16'(len));
   endtask

   task automatic wait_frames(input int target);
      int n;
      n = 0;
      while (frames_seen < target && n < MAX_WAIT) begin
         @(posedge TX_CLK);
         #1;
         n++;
      end
      if (frames_seen < target) begin
         timeouts++;
         $display("Timed out at %0t waiting for frame %0d on MII", $time, target);
      end
   endtask

   task automatic wait_ready();
      logic [15:0] st;
      int          n;
      n  = 0;
      st = '0;
      while (!st[eth_tx_pkg::STAT_READY_BIT] && n < MAX_WAIT) begin
         reg_read(eth_tx_pkg::REG_STATUS, st);
         n++;
      end
      if (!st[eth_tx_pkg::STAT_READY_BIT]) begin
         timeouts++;
         $display("Timed out at %0t waiting for the ready status bit", $time);
      end
   endtask

   task automatic wait_tx_active();
      int n;
      n = 0;
      while (!mii_tx_en && n < MAX_WAIT) begin
         @(posedge TX_CLK);
         #1;
         n++;
      end
      if (!mii_tx_en) begin
         timeouts++;
         $display("Timed out at %0t waiting for mii_tx_en to rise", $time);
      end
   endtask

   // bytes low nibble first, then fcs lsb first
   task automatic check_frame(input int len);
      logic [31:0] fcs;
      int          n_exp;
      fcs   = ref_fcs(eth_tx_pkg::HDR_BYTES, len);
      n_exp = 2 * len + eth_tx_pkg::FCS_NIBBLES;
      check_value(done_q.size(), n_exp, "nibble count");
      if (done_q.size() == n_exp) begin
         for (int i = 0; i < len; i++) begin
            check_value(32'({done_q[2*i+1], done_q[2*i]}), 32'(frame[i]),
                        $sformatf("byte %0d", i));
         end
         for (int k = 0; k < eth_tx_pkg::FCS_NIBBLES; k++) begin
            check_value(32'(done_q[2*len+k]), 32'(fcs[4*k +: 4]),
                        $sformatf("fcs nibble %0d", k));
         end
      end
   endtask

   initial begin
      logic [15:0] rd;
      logic [31:0] fcs_rx;
      int          len;
      errors          = 0;
      timeouts        = 0;
      frames_seen     = 0;
      frames_expected = 0;
      lcg_state       = 32'd62055;
      tx_rst          = 1'b1;
      reg_wr_en       = 1'b0;
      reg_addr        = '0;
      reg_wdata       = '0;
      buf_wr_en       = 1'b0;
      buf_wr_addr     = '0;
      buf_wr_data     = '0;
      accept_wr       = 1'b0;
      fcs_rx          = '0;
      repeat (5) @(posedge TX_CLK);
      #1;
      tx_rst = 1'b0;

      check_value(32'(mii_tx_en), 0, "mii_tx_en after reset");
      reg_read(eth_tx_pkg::REG_STATUS, rd);
      check_value(32'(rd[eth_tx_pkg::STAT_READY_BIT]), 1, "ready after reset");
      check_value(32'(rd[eth_tx_pkg::STAT_LOST_BIT]), 0, "lost after reset");
      reg_read(eth_tx_pkg::REG_COUNT, rd);
      check_value(32'(rd), 0, "frame count after reset");

      // known check value frame
      load_frame(eth_tx_pkg::HDR_BYTES + 9, 1'b1);
      reg_read(eth_tx_pkg::REG_LEN, rd);
      check_value(32'(rd), 17, "length readback");
      send_frame(1'b1);
      wait_frames(frames_expected);
      check_frame(17);
      for (int k = 0; k < eth_tx_pkg::FCS_NIBBLES; k++) begin
         fcs_rx[4*k +: 4] = done_q[2*17+k];
      end
      check_value(fcs_rx, 32'hCBF4_3926, "fcs of fixed frame");

      for (int f = 0; f < N_RANDOM; f++) begin
         lcg_state = lcg_next(lcg_state);
         len = eth_tx_pkg::HDR_BYTES + 1 + int'(lcg_state[21:16]);
         load_frame(len, 1'b0);
         wait_ready();
         send_frame(1'b1);
         wait_frames(frames_expected);
         check_frame(len);
      end

      // send while busy
      load_frame(40, 1'b0);
      send_frame(1'b1);
      wait_tx_active();
      send_frame(1'b0);
      wait_frames(frames_expected);
      check_frame(40);
      repeat (100) @(posedge TX_CLK);
      #1;
      check_value(frames_seen, frames_expected, "frames after busy send");
      reg_read(eth_tx_pkg::REG_STATUS, rd);
      check_value(32'(rd[eth_tx_pkg::STAT_LOST_BIT]), 1, "lost after busy send");
      reg_write(eth_tx_pkg::REG_CTRL, 16'(1 << eth_tx_pkg::CTRL_CLR_LOST_BIT));
      reg_read(eth_tx_pkg::REG_STATUS, rd);
      check_value(32'(rd[eth_tx_pkg::STAT_LOST_BIT]), 0, "lost after clear");

      // back to back frames from one buffer image
      load_frame(24, 1'b0);
      send_frame(1'b1);
      wait_ready();
      send_frame(1'b1);
      wait_frames(frames_expected - 1);
      check_frame(24);
      wait_frames(frames_expected);
      check_frame(24);

      repeat (3) @(posedge TX_CLK);
      #1;
      reg_read(eth_tx_pkg::REG_STATUS, rd);
      check_value(32'(rd[eth_tx_pkg::STAT_READY_BIT]), 1, "ready at end");
      check_value(32'(rd[eth_tx_pkg::STAT_LOST_BIT]), 0, "lost at end");
      reg_read(eth_tx_pkg::REG_COUNT, rd);
      check_value(32'(rd), frames_expected, "frame count");
      check_value(frames_seen, frames_expected, "frames seen on MII");

      $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: eth_tx.f
source/eth_tx_pkg.sv
source/eth_tx_frame_buf.sv
source/eth_tx_ctrl_regs.sv
source/eth_crc32.sv
source/eth_mii_tx.sv
source/eth_tx_top.sv
sim/eth_tx_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := eth_tx_tb
FILELIST   := eth_tx.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
